//--- design/core_macros.svh
////////////////////////////////////////////////////////////
// Widths, decode buffer geometry and opcode byte values
// shared by the core and its testbench
////////////////////////////////////////////////////////////
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define ADDR_W          64
`define DATA_W          64

`define LINE_BYTES      64     // one bus request
`define BEAT_BYTES      8      // one response beat
`define BUF_BYTES       128    // circular decode buffer, two lines
`define MAX_INST_BYTES  7      // longest supported instruction

`define NUM_REGS        8

`define OP_NOP          8'h90
`define OP_HLT          8'hF4
`define OP_REXW         8'h48  // REX.W prefix
`define OP_ADD          8'h01  // add r/m64, r64
`define OP_SUB          8'h29  // sub r/m64, r64
`define OP_MOVI         8'hC7  // mov r/m64, imm32 sign extended

`endif

//--- design/corePkg.sv
////////////////////////////////////////////////////////////
// Core types: vector widths, FSM and ALU enums and the
// records passed between pipeline stages
////////////////////////////////////////////////////////////
`include "core_macros.svh"

package corePkg;

   typedef logic [`ADDR_W-1:0]                   addrT;
   typedef logic [`DATA_W-1:0]                   wordT;
   typedef logic [$clog2(`NUM_REGS)-1:0]         regIdxT;
   typedef logic [$clog2(`BUF_BYTES):0]          bufPtrT;      // top bit is the wrap bit
   typedef logic [$clog2(`MAX_INST_BYTES+1)-1:0] instLenT;
   typedef logic [`MAX_INST_BYTES*8-1:0]         byteWindowT;  // byte 0 in the low bits

   typedef enum logic [1:0] {
      fetchIdle,
      fetchWaiting,
      fetchActive
   } fetchStateT;

   typedef enum logic [1:0] {
      aluAdd,
      aluSub,
      aluMov
   } aluOpT;

   typedef struct packed {
      logic   valid;
      aluOpT  aluOp;
      regIdxT dest;
      regIdxT src;
      wordT   imm;      // already sign extended
   } issueT;

   typedef struct packed {
      logic   valid;
      aluOpT  aluOp;
      regIdxT dest;
      wordT   opA;
      wordT   opB;
   } operandT;

   typedef struct packed {
      logic   valid;
      regIdxT dest;
      wordT   value;
   } retireT;

endpackage

//--- design/fetchUnit.sv
////////////////////////////////////////////////////////////
// Fetch unit. Requests 64-byte lines, fills the circular
// decode buffer and offers a byte window to the decoder
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_macros.svh"

module fetchUnit import corePkg::*; (
   input  logic       bus,
   input  logic       rstN,
   input  addrT       entry,
   output logic       reqCyc,
   output addrT       reqAddr,
   input  logic       reqAck,
   input  logic       respCyc,
   input  wordT       resp,
   output byteWindowT window,
   output instLenT    availBytes,
   input  instLenT    consumed
);
   localparam int beatsPerLine = `LINE_BYTES / `BEAT_BYTES;
   localparam int beatBits     = `BEAT_BYTES * 8;
   localparam int offBits      = $clog2(`BEAT_BYTES);
   localparam int lineBits     = $clog2(`LINE_BYTES);
   localparam int ptrBits      = $clog2(`BUF_BYTES);

   fetchStateT                      fetchState;
   addrT                            lineAddr;    // next sequential line
   logic                            firstLine;   // still fetching the line holding entry
   logic [$clog2(beatsPerLine)-1:0] beatCnt;
   logic [$clog2(beatsPerLine)-1:0] entryBeat;
   bufPtrT                          fillPtr;
   bufPtrT                          decPtr;
   bufPtrT                          usedBytes;
   logic [`BUF_BYTES*8-1:0]         decodeBuf;
   logic                            keepBeat;
   logic                            lastBeat;
   logic                            lineFits;

   assign entryBeat = entry[lineBits-1:offBits];
   assign reqAddr   = firstLine ? (entry & ~addrT'(`LINE_BYTES - 1)) : lineAddr;
   assign lastBeat  = (beatCnt == ($clog2(beatsPerLine))'(beatsPerLine - 1));
   // beats ahead of entry in the first line are dropped
   assign keepBeat  = respCyc && (fetchState != fetchIdle) &&
                      !(firstLine && (beatCnt < entryBeat));

   assign usedBytes  = fillPtr - decPtr;
   assign lineFits   = usedBytes <= bufPtrT'(`BUF_BYTES - `LINE_BYTES);
   assign availBytes = (usedBytes >= bufPtrT'(`MAX_INST_BYTES)) ?
                       instLenT'(`MAX_INST_BYTES) : instLenT'(usedBytes);

   always_ff @(posedge bus or negedge rstN) begin
      if (!rstN) begin
         fetchState <= fetchIdle;
         reqCyc     <= 1'b0;
         lineAddr   <= '0;
         firstLine  <= 1'b1;
         beatCnt    <= '0;
         fillPtr    <= '0;
         decPtr     <= '0;
      end else begin
         decPtr <= decPtr + bufPtrT'(consumed);
         case (fetchState)
            fetchIdle: begin
               if (reqCyc && reqAck) begin
                  reqCyc     <= 1'b0;
                  lineAddr   <= reqAddr + addrT'(`LINE_BYTES);
                  fetchState <= fetchWaiting;
               end else if (!reqCyc && lineFits) begin
                  reqCyc <= 1'b1;   // a whole line fits in the buffer
               end
            end
            default: begin
               if (respCyc) begin
                  beatCnt <= beatCnt + 1'b1;
                  if (keepBeat)
                     fillPtr <= fillPtr + bufPtrT'(`BEAT_BYTES);
                  if (lastBeat) begin
                     fetchState <= fetchIdle;
                     firstLine  <= 1'b0;
                  end else begin
                     fetchState <= fetchActive;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge bus) begin
      if (keepBeat)
         decodeBuf[fillPtr[ptrBits-1:offBits]*beatBits +: beatBits] <= resp;
   end

   always_comb begin
      logic [ptrBits-1:0] rdIdx;
      for (int i = 0; i < `MAX_INST_BYTES; i++) begin
         rdIdx = decPtr[ptrBits-1:0] + ptrBits'(i);   // wraps around the buffer end
         window[i*8 +: 8] = decodeBuf[rdIdx*8 +: 8];
      end
   end

   respWhileIdle: assert property (@(posedge bus) disable iff (!rstN)
      respCyc |-> fetchState != fetchIdle)
      else $error("fetchUnit: response beat without an acknowledged request");

   entryAligned: assert property (@(posedge bus) disable iff (!rstN)
      entry[offBits-1:0] == '0)
      else $error("fetchUnit: entry %h is not 8-byte aligned", entry);

endmodule

//--- design/instDecoder.sv
////////////////////////////////////////////////////////////
// Instruction decoder for NOP, HLT, ADD, SUB and MOV imm32.
// Stalls on short data or a busy register, detects halt
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_macros.svh"

module instDecoder import corePkg::*; (
   input  logic                 bus,
   input  logic                 rstN,
   input  byteWindowT           window,
   input  instLenT              availBytes,
   input  logic [`NUM_REGS-1:0] inUse,
   output instLenT              consumed,
   output issueT                issue,
   output logic                 halted
);
   logic [7:0]           opByte;
   logic [7:0]           aluByte;
   logic [7:0]           modRm;
   logic [31:0]          imm32;
   regIdxT               dest;
   regIdxT               src;
   instLenT              instLen;
   aluOpT                aluOp;
   logic                 isAlu;
   logic                 isHalt;
   logic [`NUM_REGS-1:0] busy;
   logic                 hazard;
   logic                 take;
   logic                 haltSeen;
   issueT                issueNext;

   assign opByte  = window[7:0];
   assign aluByte = window[15:8];
   assign modRm   = window[23:16];
   assign imm32   = window[55:24];
   assign dest    = modRm[2:0];   // rm field, register form only
   assign src     = modRm[5:3];

   // length is known from the first two bytes
   always_comb begin
      instLen = instLenT'(1);
      aluOp   = aluAdd;
      isAlu   = 1'b0;
      isHalt  = (opByte == `OP_HLT);
      if (opByte == `OP_REXW) begin
         instLen = instLenT'(3);
         isAlu   = 1'b1;
         case (aluByte)
            `OP_ADD: aluOp = aluAdd;
            `OP_SUB: aluOp = aluSub;
            `OP_MOVI: begin
               aluOp   = aluMov;
               instLen = instLenT'(`MAX_INST_BYTES);
            end
            default: isAlu = 1'b0;
         endcase
      end
   end

   always_comb begin
      busy = inUse;
      if (issue.valid)
         busy[issue.dest] = 1'b1;   // regFile sets this bit one edge later
   end

   assign hazard   = isAlu && (busy[dest] || (aluOp != aluMov && busy[src]));
   assign take     = !haltSeen && (availBytes >= instLen) && !hazard;
   assign consumed = take ? instLen : '0;

   always_comb begin
      issueNext.valid = take && isAlu;
      issueNext.aluOp = aluOp;
      issueNext.dest  = dest;
      issueNext.src   = src;
      issueNext.imm   = (aluOp == aluMov) ? {{(`DATA_W-32){imm32[31]}}, imm32} : '0;
   end

   always_ff @(posedge bus or negedge rstN) begin
      if (!rstN) begin
         issue    <= '0;
         haltSeen <= 1'b0;
         halted   <= 1'b0;
      end else begin
         issue <= issueNext;
         if (take && isHalt)
            haltSeen <= 1'b1;
         if (haltSeen && busy == '0)
            halted <= 1'b1;   // all writes have retired
      end
   end

   consumeFits: assert property (@(posedge bus) disable iff (!rstN)
      consumed <= availBytes)
      else $error("instDecoder: consumed %0d with only %0d bytes buffered",
                  consumed, availBytes);

endmodule

//--- design/regFile.sv
////////////////////////////////////////////////////////////
// Register file with in-use scoreboard and the registered
// operand read stage
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_macros.svh"

module regFile import corePkg::*; (
   input  logic                 bus,
   input  logic                 rstN,
   input  issueT                issue,
   input  retireT               retire,
   output operandT              operand,
   output logic [`NUM_REGS-1:0] inUse
);
   wordT regs [`NUM_REGS];

   always_ff @(posedge bus or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `NUM_REGS; i++)
            regs[i] <= '0;
         inUse <= '0;
      end else begin
         if (retire.valid) begin
            regs[retire.dest]  <= retire.value;
            inUse[retire.dest] <= 1'b0;
         end
         if (issue.valid)
            inUse[issue.dest] <= 1'b1;   // set wins over a same-cycle clear
      end
   end

   // read stage
   always_ff @(posedge bus or negedge rstN) begin
      if (!rstN) begin
         operand <= '0;
      end else begin
         operand.valid <= issue.valid;
         operand.aluOp <= issue.aluOp;
         operand.dest  <= issue.dest;
         operand.opA   <= regs[issue.dest];
         operand.opB   <= (issue.aluOp == aluMov) ? issue.imm : regs[issue.src];
      end
   end

   retireOwned: assert property (@(posedge bus) disable iff (!rstN)
      retire.valid |-> inUse[retire.dest])
      else $error("regFile: retire to r%0d which is not in use", retire.dest);

endmodule

//--- design/execUnit.sv
////////////////////////////////////////////////////////////
// Execute stage. ALU and the writeback register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execUnit import corePkg::*; (
   input  logic    bus,
   input  logic    rstN,
   input  operandT operand,
   output retireT  retire
);
   wordT result;

   always_comb begin
      case (operand.aluOp)
         aluAdd:  result = operand.opA + operand.opB;
         aluSub:  result = operand.opA - operand.opB;   // dest minus src
         default: result = operand.opB;                 // mov passes the immediate
      endcase
   end

   always_ff @(posedge bus or negedge rstN) begin
      if (!rstN) begin
         retire <= '0;
      end else begin
         retire.valid <= operand.valid;
         retire.dest  <= operand.dest;
         retire.value <= result;
      end
   end

endmodule

//--- design/core.sv
////////////////////////////////////////////////////////////
// Core top level. Fetch, decode, read, execute and
// writeback stages with the retire ports
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_macros.svh"

module core import corePkg::*; (
   input  logic   bus,
   input  logic   rstN,
   input  addrT   entry,
   output logic   reqCyc,
   output addrT   reqAddr,
   input  logic   reqAck,
   input  logic   respCyc,
   input  wordT   resp,
   output logic   retireValid,
   output regIdxT retireReg,
   output wordT   retireValue,
   output logic   halted
);
   byteWindowT           window;
   instLenT              availBytes;
   instLenT              consumed;
   issueT                issue;
   logic [`NUM_REGS-1:0] inUse;
   operandT              operand;
   retireT               retire;

   fetchUnit fetchUnit_inst (
      .bus        (bus),
      .rstN       (rstN),
      .entry      (entry),
      .reqCyc     (reqCyc),
      .reqAddr    (reqAddr),
      .reqAck     (reqAck),
      .respCyc    (respCyc),
      .resp       (resp),
      .window     (window),
      .availBytes (availBytes),
      .consumed   (consumed)
   );

   instDecoder instDecoder_inst (
      .bus        (bus),
      .rstN       (rstN),
      .window     (window),
      .availBytes (availBytes),
      .inUse      (inUse),
      .consumed   (consumed),
      .issue      (issue),
      .halted     (halted)
   );

   regFile regFile_inst (
      .bus     (bus),
      .rstN    (rstN),
      .issue   (issue),
      .retire  (retire),
      .operand (operand),
      .inUse   (inUse)
   );

   execUnit execUnit_inst (
      .bus     (bus),
      .rstN    (rstN),
      .operand (operand),
      .retire  (retire)
   );

   assign retireValid = retire.valid;
   assign retireReg   = retire.dest;
   assign retireValue = retire.value;

endmodule

//--- testbench/clockGen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset. 20 ns clock, reset held low
// for 3 cycles at start and on each request
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clockGen (
   input  logic resetReq,
   output logic bus,
   output logic rstN
);
   logic       resetSeen = 1'b0;
   logic [1:0] lowCnt = 2'd3;

   initial begin
      bus  = 1'b0;
      rstN = 1'b0;
      forever #10 bus = ~bus;
   end

   always @(posedge bus) resetSeen <= resetReq;

   always @(negedge bus) begin
      if (resetSeen) begin
         rstN   <= 1'b0;
         lowCnt <= 2'd3;
      end else if (lowCnt != 2'd0) begin
         lowCnt <= lowCnt - 2'd1;
         if (lowCnt == 2'd1)
            rstN <= 1'b1;   // release on a falling edge
      end
   end

endmodule

//--- testbench/coreTb.sv
////////////////////////////////////////////////////////////
// Core testbench. Bus memory model, programs and expected
// register writes from the tests file, retire checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_macros.svh"

module coreTb import corePkg::*; ();
   localparam int maxCycles = 400;
   localparam int imgWords  = 32;   // 256 byte program image

   logic       bus;
   logic       rstN;
   logic       resetReq;
   addrT       entry;
   logic       reqCyc;
   addrT       reqAddr;
   logic       reqAck;
   logic       respCyc;
   wordT       resp;
   logic       retireValid;
   regIdxT     retireReg;
   wordT       retireValue;
   logic       halted;

   logic [63:0] tests [0:255];
   wordT        image [0:imgWords-1];
   logic [63:0] expReg [0:31];
   wordT        expVal [0:31];
   logic [15:0] lfsr = 16'd31761;
   int          errors = 0;
   int          numTests = 0;
   bit          loaded = 0;
   int          nExp;
   int          expIdx;
   string       curName;
   int          memState;
   int          delay;
   int          beatIdx;
   addrT        lineAddr;
   bit          firstReqSeen;

   clockGen clockGen_inst (.resetReq(resetReq), .bus(bus), .rstN(rstN));

   core core_inst (
      .bus         (bus),
      .rstN        (rstN),
      .entry       (entry),
      .reqCyc      (reqCyc),
      .reqAddr     (reqAddr),
      .reqAck      (reqAck),
      .respCyc     (respCyc),
      .resp        (resp),
      .retireValid (retireValid),
      .retireReg   (retireReg),
      .retireValue (retireValue),
      .halted      (halted)
   );

   function automatic string testName(input int idx);
      case (idx)
         0: return "movSignExt";
         1: return "depChain";
         2: return "midLineEntry";
         3: return "backToBack";
         default: return "unnamed";
      endcase
   endfunction

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic pickDelay(output int d);
      d = 0;
      for (int i = 0; i < 2; i++) begin
         lfsr = lfsrNext(lfsr);
         d = (d << 1) | int'(lfsr[0]);
      end
   endtask

   function automatic wordT readMemWord(input addrT a);
      if (a < addrT'(imgWords * 8))
         return image[a[7:3]];
      return a ^ {a[31:0], a[63:32]} ^ 64'hA5A5_5A5A_C3C3_3C3C;   // unmapped space
   endfunction

   task automatic driveBeat();
      respCyc = 1'b1;
      resp    = readMemWord(lineAddr + addrT'(beatIdx * `BEAT_BYTES));
      beatIdx++;
   endtask

   // request/acknowledge bus, eight beats per line
   task automatic serveMemory();
      case (memState)
         0: begin
            respCyc = 1'b0;
            if (reqCyc) begin
               if (!firstReqSeen && reqAddr != (entry & ~addrT'(`LINE_BYTES - 1))) begin
                  $display("[FAIL] %s: first request expected %h, actual %h", curName,
                           entry & ~addrT'(`LINE_BYTES - 1), reqAddr);
                  errors++;
               end
               firstReqSeen = 1;
               lineAddr = reqAddr;
               pickDelay(delay);
               if (delay == 0) begin
                  reqAck   = 1'b1;
                  memState = 2;
               end else begin
                  memState = 1;
               end
            end
         end
         1: begin
            delay--;
            if (delay == 0) begin
               reqAck   = 1'b1;
               memState = 2;
            end
         end
         2: begin
            reqAck  = 1'b0;
            beatIdx = 0;
            pickDelay(delay);
            if (delay == 0) begin
               driveBeat();
               memState = 4;
            end else begin
               memState = 3;
            end
         end
         3: begin
            delay--;
            if (delay == 0) begin
               driveBeat();
               memState = 4;
            end
         end
         default: begin
            if (beatIdx < `LINE_BYTES / `BEAT_BYTES) begin
               driveBeat();
            end else begin
               respCyc  = 1'b0;
               memState = 0;
            end
         end
      endcase
   endtask

   task automatic checkRetire();
      if (expIdx >= nExp) begin
         $display("%s: unexpected extra write to r%0d", curName, retireReg);
         errors++;
      end else begin
         if (retireReg != regIdxT'(expReg[expIdx]) || retireValue != expVal[expIdx]) begin
            $display("[FAIL] %s: expected r%0d=%h, actual r%0d=%h", curName,
                     expReg[expIdx], expVal[expIdx], retireReg, retireValue);
            errors++;
         end
      end
      expIdx++;
   endtask

   initial begin
      int p;
      int nWords;
      int cycles;
      int haltWait;
      resetReq = 1'b0;
      entry    = '0;
      reqAck   = 1'b0;
      respCyc  = 1'b0;
      resp     = '0;
      for (int i = 0; i < 256; i++)
         tests[i] = '0;
      $readmemh("testbench/coreTests.mem", tests);
      numTests = int'(tests[0]);
      loaded   = 1;
      p = 1;
      for (int t = 0; t < numTests; t++) begin
         curName = testName(int'(tests[p]));
         nWords  = int'(tests[p+2]);
         nExp    = int'(tests[p+3]);
         for (int i = 0; i < imgWords; i++)
            image[i] = readMemWord(addrT'(imgWords * 8)) ^ wordT'(i * 8);
         for (int i = 0; i < nWords; i++)
            image[i] = tests[p+4+i];
         for (int i = 0; i < nExp; i++) begin
            expReg[i] = tests[p+4+nWords+2*i];
            expVal[i] = tests[p+5+nWords+2*i];
         end
         @(negedge bus);
         entry        = addrT'(tests[p+1]);
         memState     = 0;
         reqAck       = 1'b0;
         respCyc      = 1'b0;
         firstReqSeen = 0;
         expIdx       = 0;
         resetReq     = 1'b1;
         @(negedge bus);
         resetReq = 1'b0;
         @(posedge rstN);
         if (reqCyc || retireValid || halted) begin
            $display("%s: outputs not low after reset", curName);
            errors++;
         end
         cycles   = 0;
         haltWait = -1;
         while (cycles < maxCycles && haltWait < 10) begin
            @(negedge bus);
            serveMemory();
            if (retireValid)
               checkRetire();   // also catches a write after halt
            if (halted) begin
               if (haltWait < 0 && expIdx != nExp) begin
                  $display("%s: halted rose after %0d of %0d writes", curName,
                           expIdx, nExp);
                  errors++;
               end
               haltWait++;
            end
            cycles++;
         end
         if (!halted) begin
            $display("%s: halted never rose within %0d cycles", curName, maxCycles);
            errors++;
         end
         if (expIdx != nExp) begin
            $display("%s: %0d writes retired, %0d expected", curName, expIdx, nExp);
            errors++;
         end
         p = p + 4 + nWords + 2 * nExp;
      end
      $display("%0d tests run, %0d errors", numTests, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      wait (loaded);
      #(numTests * (maxCycles + 20) * 20);
      $display("watchdog: run did not finish in time");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- testbench/coreTests.mem
// first the test count, then per test: name index, entry, image words, expected writes,
// image words (byte 0 in the low bits), then register and value pairs
4
// mov sign extension, nop and hlt
0 0 2 2
9012345678C0C748 F4FFFFFFFEC1C748
0 0000000012345678
1 FFFFFFFFFFFFFFFE
// dependent add and sub chain
1 0 4 6
4800000005C0C748 014800000003C1C7 48C10148C82948C8 9090909090F4C829
0 0000000000000005
1 0000000000000003
0 0000000000000008
0 0000000000000005
1 0000000000000008
0 FFFFFFFFFFFFFFFD
// entry partway into the first line, mov straddles the line boundary
2 38 9 2
9000000BADC2C748 9000000BADC2C748 9000000BADC2C748 9000000BADC2C748
9000000BADC2C748 9000000BADC2C748 9000000BADC2C748
00C3C74890909090 90F4DB0148800000
3 FFFFFFFF80000000
3 FFFFFFFF00000000
// back to back independent movs
3 0 4 4
4800000001C4C748 C74800000002C5C7 C7C74800000003C6 909090F4FFFFFFFF
4 0000000000000001
5 0000000000000002
6 0000000000000003
7 FFFFFFFFFFFFFFFF

//--- sources.f
+incdir+design
design/corePkg.sv
design/fetchUnit.sv
design/instDecoder.sv
design/regFile.sv
design/execUnit.sv
design/core.sv
testbench/clockGen.sv
testbench/coreTb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module coreTb -f sources.f -o coreSim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
   exit 1
fi
exit 0
